// ==== build.f ====
verilog/fp_seq_pkg.sv
verilog/fp_decoder.sv
verilog/fp_scoreboard.sv
verilog/fp_regfile.sv
verilog/fp_dispatch.sv
verilog/fp_retire.sv
verilog/fp_sequencer.sv
tests/tb_fp_sequencer.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the FP sequencer testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -j 0 --top-module tb_fp_sequencer -f build.f
./obj_dir/Vtb_fp_sequencer > sim.log 2>&1 || true
cat sim.log

if grep -q "tests failed" sim.log; then
  exit 1
fi
exit 0

// ==== tests/tb_fp_sequencer.sv ====
//////////////////////////////
// FP issue sequencer testbench
// Accelerator model, reference decode and result checks
//////////////////////////////

`default_nettype none

module tb_fp_sequencer import fp_seq_pkg::*; ();

  localparam int unsigned CLK_PERIOD = 20;
  localparam int unsigned NUM_OPS    = 120;
  localparam int unsigned MAX_CYCLES = 40;
  localparam int unsigned NUM_ARITH  = 40;

  // Bit positions in the decode_ref result
  localparam int B_FD  = 6;
  localparam int B_FS1 = 5;
  localparam int B_FS2 = 4;
  localparam int B_FS3 = 3;
  localparam int B_RD  = 2;
  localparam int B_MV  = 1;
  localparam int B_ILL = 0;

  logic     clk;
  logic     rst_n;
  logic     issue_valid;
  instr_t   issue_instr;
  core_id_t issue_id;
  xlen_t    issue_rs1;
  xlen_t    issue_rs2;
  xlen_t    issue_rs3;
  logic     issue_ready;
  logic     issue_accept;
  logic     issue_writeback;
  logic     issue_exc;
  logic     acc_valid;
  instr_t   acc_instr;
  acc_tag_t acc_tag;
  xlen_t    acc_rs1;
  xlen_t    acc_rs2;
  xlen_t    acc_rs3;
  logic     acc_ready;
  logic     acc_accept;
  logic     acc_writeback;
  logic     acc_result_valid;
  acc_tag_t acc_result_tag;
  fp_data_t acc_result_data;
  logic     acc_result_ready;
  logic     core_result_valid;
  core_id_t core_result_id;
  xlen_t    core_result_data;
  logic     core_result_ready;

  // Shadow FPR, expected pending bits and result queues
  fp_data_t shadow_fpr [NR_FP_REG];
  logic     pending [NR_FP_REG] = '{default: 1'b0};
  core_id_t exp_id_q [$];
  fp_data_t exp_data_q [$];
  acc_tag_t res_tag_q [$];
  fp_data_t res_data_q [$];
  int       res_delay_q [$];
  int       stall_seen = 0;
  // Expected state of the move holding register
  logic     move_held = 1'b0;

  initial clk = 1'b0;
  always #(CLK_PERIOD / 2) clk = ~clk;

  fp_sequencer dut0 (
    .clk_i              (clk),
    .rst_n_i            (rst_n),
    .issue_valid_i      (issue_valid),
    .issue_instr_i      (issue_instr),
    .issue_id_i         (issue_id),
    .issue_rs1_i        (issue_rs1),
    .issue_rs2_i        (issue_rs2),
    .issue_rs3_i        (issue_rs3),
    .issue_ready_o      (issue_ready),
    .issue_accept_o     (issue_accept),
    .issue_writeback_o  (issue_writeback),
    .issue_exc_o        (issue_exc),
    .acc_valid_o        (acc_valid),
    .acc_instr_o        (acc_instr),
    .acc_tag_o          (acc_tag),
    .acc_rs1_o          (acc_rs1),
    .acc_rs2_o          (acc_rs2),
    .acc_rs3_o          (acc_rs3),
    .acc_ready_i        (acc_ready),
    .acc_accept_i       (acc_accept),
    .acc_writeback_i    (acc_writeback),
    .acc_result_valid_i (acc_result_valid),
    .acc_result_tag_i   (acc_result_tag),
    .acc_result_data_i  (acc_result_data),
    .acc_result_ready_o (acc_result_ready),
    .core_result_valid_o(core_result_valid),
    .core_result_id_o   (core_result_id),
    .core_result_data_o (core_result_data),
    .core_result_ready_i(core_result_ready)
  );

  ////////////////////////////////
  // Checks and reference model
  ////////////////////////////////

  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("tests failed");
    $fatal(1);
  endtask

  task automatic check_data(input string name, input fp_data_t got, input fp_data_t exp);
    if (got !== exp)
      stop_on_error($sformatf("ERROR: %s got %h expected %h", name, got, exp));
  endtask

  task automatic check_instr(input string name, input instr_t got, input instr_t exp);
    if (got !== exp)
      stop_on_error($sformatf("ERROR: %s got %h expected %h", name, got, exp));
  endtask

  task automatic check_id(input string name, input core_id_t got, input core_id_t exp);
    if (got !== exp)
      stop_on_error($sformatf("ERROR: %s got %h expected %h", name, got, exp));
  endtask

  task automatic check_tag(input string name, input acc_tag_t got, input acc_tag_t exp);
    if (got !== exp)
      stop_on_error($sformatf("ERROR: %s got %h expected %h", name, got, exp));
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp)
      stop_on_error($sformatf("ERROR: %s got %h expected %h", name, got, exp));
  endtask

  // Flags {fd, fs1, fs2, fs3, rd, move, illegal}
  function automatic logic [6:0] decode_ref(input instr_t instr);
    logic [6:0] opc;
    logic [4:0] f5;
    logic [2:0] f3;
    logic       fmt_ok;
    logic [6:0] r;
    opc    = instr[6:0];
    f5     = instr[31:27];
    f3     = instr[14:12];
    fmt_ok = !instr[26];
    r      = 7'b0000000;
    if (opc == OPC_FMADD || opc == OPC_FMSUB || opc == OPC_FNMSUB || opc == OPC_FNMADD) begin
      r = fmt_ok ? 7'b1111000 : 7'b0000001;
    end else if (opc == OPC_OP_FP && !fmt_ok) begin
      r = 7'b0000001;
    end else if (opc == OPC_OP_FP) begin
      case (f5)
        F5_ADD, F5_SUB, F5_MUL, F5_DIV, F5_SGNJ, F5_MINMAX: r = 7'b1110000;
        F5_SQRT:    r = 7'b1100000;
        F5_CMP:     r = 7'b0110000;
        F5_CVT_INT: r = 7'b0100000;
        F5_CVT_FP:  r = 7'b1000000;
        F5_MV_X:    r = (f3 == 3'b000) ? 7'b0100110 :
                        (f3 == 3'b001) ? 7'b0100000 : 7'b0000001;
        F5_MV_F:    r = 7'b1000010;
        default:    r = 7'b0000001;
      endcase
    end
    return r;
  endfunction

  function automatic instr_t op_fp(input funct5_t f5, input logic [1:0] fmt, input int fs2,
                                   input int fs1, input logic [2:0] f3, input int fd);
    return {f5, fmt, 5'(fs2), 5'(fs1), f3, 5'(fd), OPC_OP_FP};
  endfunction

  function automatic instr_t fma(input opcode_t opc, input int fs3, input logic [1:0] fmt,
                                 input int fs2, input int fs1, input int fd);
    return {5'(fs3), fmt, 5'(fs2), 5'(fs1), 3'b000, 5'(fd), opc};
  endfunction

  function automatic int rand_reg();
    return $urandom_range(0, 31);
  endfunction

  // Compare on the falling edge, ahead of the transfer edge
  always @(negedge clk) begin : compare
    logic [6:0]   ref_f;
    logic         is_local;
    logic         sb_stall;
    logic         mv_stall;
    logic         acc_to_core;
    logic         move_taken;
    fp_reg_addr_t fd;
    fp_reg_addr_t fs1;
    fp_reg_addr_t fs2;
    fp_reg_addr_t fs3;
    acc_tag_t     exp_tag;
    fp_data_t     res_data;
    if (rst_n) begin
      ref_f    = decode_ref(issue_instr);
      fd       = issue_instr[11:7];
      fs1      = issue_instr[19:15];
      fs2      = issue_instr[24:20];
      fs3      = issue_instr[31:27];
      is_local = ref_f[B_MV] || ref_f[B_ILL];
      // Stall on a pending register or on a full move register
      sb_stall = (ref_f[B_FD] && pending[fd]) || (ref_f[B_FS1] && pending[fs1]) ||
                 (ref_f[B_FS2] && pending[fs2]) || (ref_f[B_FS3] && pending[fs3]);
      mv_stall = ref_f[B_MV] && ref_f[B_RD] && move_held;
      check_flag("acc_valid_o", acc_valid, issue_valid && !is_local && !sb_stall);
      if (issue_valid) begin
        if (sb_stall)
          stall_seen++;
        check_flag("issue_ready_o", issue_ready,
                   !sb_stall && !mv_stall && (is_local || acc_ready));
      end
      // Non-FP accelerator results go ahead of the held move result
      acc_to_core = acc_result_valid && !acc_result_tag[ID_W];
      check_flag("core_result_valid_o", core_result_valid, acc_to_core || move_held);
      move_taken = move_held && !acc_to_core && core_result_ready;
      if (core_result_valid) begin
        if (exp_id_q.size() == 0)
          stop_on_error("A core result appeared while none was expected");
        check_id("core_result_id_o", core_result_id, exp_id_q[0]);
        check_data("core_result_data_o", core_result_data, exp_data_q[0]);
        if (core_result_ready) begin
          void'(exp_id_q.pop_front());
          void'(exp_data_q.pop_front());
        end
      end
      if (acc_result_valid) begin
        if (acc_result_tag[ID_W])
          check_flag("acc_result_ready_o", acc_result_ready, 1'b1);
        else
          check_flag("acc_result_ready_o", acc_result_ready, core_result_ready);
      end
      if (issue_valid && issue_ready) begin
        if (is_local) begin
          check_flag("acc_valid_o", acc_valid, 1'b0);
          check_flag("issue_accept_o", issue_accept, ref_f[B_MV]);
          check_flag("issue_writeback_o", issue_writeback, ref_f[B_MV] && ref_f[B_RD]);
          check_flag("issue_exc_o", issue_exc, ref_f[B_ILL]);
          if (ref_f[B_MV] && ref_f[B_FD])
            shadow_fpr[fd] = issue_rs1;
          if (ref_f[B_MV] && ref_f[B_RD]) begin
            exp_id_q.push_back(issue_id);
            exp_data_q.push_back(shadow_fpr[fs1]);
            move_held = 1'b1;
          end
        end else begin
          check_flag("acc_valid_o", acc_valid, 1'b1);
          check_instr("acc_instr_o", acc_instr, issue_instr);
          check_data("acc_rs1_o", acc_rs1, ref_f[B_FS1] ? shadow_fpr[fs1] : issue_rs1);
          check_data("acc_rs2_o", acc_rs2, ref_f[B_FS2] ? shadow_fpr[fs2] : issue_rs2);
          check_data("acc_rs3_o", acc_rs3, ref_f[B_FS3] ? shadow_fpr[fs3] : issue_rs3);
          exp_tag = ref_f[B_FD] ? {1'b1, fd} : {1'b0, issue_id};
          check_tag("acc_tag_o", acc_tag, exp_tag);
          check_flag("issue_accept_o", issue_accept, acc_accept);
          check_flag("issue_writeback_o", issue_writeback, acc_writeback);
          if (ref_f[B_FD])
            pending[fd] = 1'b1;
          res_data = $urandom;
          res_tag_q.push_back(exp_tag);
          res_data_q.push_back(res_data);
          res_delay_q.push_back($urandom_range(2, 6));
          if (!ref_f[B_FD]) begin
            exp_id_q.push_back(issue_id);
            exp_data_q.push_back(res_data);
          end
        end
      end
      // Flagged results retire into the FPR
      if (acc_result_valid && acc_result_tag[ID_W]) begin
        shadow_fpr[acc_result_tag[FP_REG_W-1:0]] = acc_result_data;
        pending[acc_result_tag[FP_REG_W-1:0]]    = 1'b0;
      end
      if (acc_result_valid && acc_result_ready) begin
        void'(res_tag_q.pop_front());
        void'(res_data_q.pop_front());
        void'(res_delay_q.pop_front());
      end
      if (move_taken)
        move_held = 1'b0;
    end
  end

  ////////////////////////////////
  // Accelerator model
  ////////////////////////////////

  initial begin : acc_model
    int   wait_cnt;
    logic taken;
    wait_cnt         = 0;
    acc_ready        = 1'b0;
    acc_accept       = 1'b0;
    acc_writeback    = 1'b0;
    acc_result_valid = 1'b0;
    acc_result_tag   = '0;
    acc_result_data  = '0;
    forever begin
      @(negedge clk);
      taken = acc_result_valid && acc_result_ready;
      @(posedge clk);
      acc_ready     <= ($urandom_range(0, 3) != 0);
      // Response bits only pass through the sequencer
      acc_accept    <= 1'($urandom_range(0, 1));
      acc_writeback <= 1'($urandom_range(0, 1));
      if (taken) begin
        acc_result_valid <= 1'b0;
      end else if (!acc_result_valid && res_tag_q.size() != 0) begin
        if (wait_cnt >= res_delay_q[0]) begin
          acc_result_valid <= 1'b1;
          acc_result_tag   <= res_tag_q[0];
          acc_result_data  <= res_data_q[0];
          wait_cnt = 0;
        end else begin
          wait_cnt++;
        end
      end
    end
  end

  ////////////////////////////////
  // Stimulus
  ////////////////////////////////

  task automatic issue_op(input instr_t instr, input int id, input xlen_t rs1);
    @(posedge clk);
    issue_valid <= 1'b1;
    issue_instr <= instr;
    issue_id    <= 5'(id);
    issue_rs1   <= rs1;
    issue_rs2   <= $urandom;
    issue_rs3   <= $urandom;
    do @(negedge clk); while (!issue_ready);
    @(posedge clk);
    issue_valid <= 1'b0;
  endtask

  task automatic drain_results();
    do @(negedge clk); while (res_tag_q.size() != 0 || exp_id_q.size() != 0);
  endtask

  initial begin : watchdog
    #(NUM_OPS * MAX_CYCLES * CLK_PERIOD);
    stop_on_error("Watchdog expired, the sequencer stopped making progress");
  end

  initial begin : main
    int         r;
    int         kind;
    logic [1:0] fmt;
    instr_t     instr;
    void'($urandom(32'h56fd));
    rst_n             = 1'b0;
    issue_valid       = 1'b0;
    issue_instr       = '0;
    issue_id          = '0;
    issue_rs1         = '0;
    issue_rs2         = '0;
    issue_rs3         = '0;
    core_result_ready = 1'b1;
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;

    // Moves into and out of every register
    for (r = 0; r < 32; r++)
      issue_op(op_fp(F5_MV_F, 2'b00, 0, r, 3'b000, r), r, $urandom);
    for (r = 0; r < 32; r++)
      issue_op(op_fp(F5_MV_X, 2'b00, 0, r, 3'b000, 31 - r), 31 - r, $urandom);
    drain_results();

    // Random forwarded arithmetic
    for (r = 0; r < NUM_ARITH; r++) begin
      kind = $urandom_range(0, 9);
      fmt  = 2'($urandom_range(0, 1));
      case (kind)
        0: instr = op_fp(F5_ADD, fmt, rand_reg(), rand_reg(), 3'b000, rand_reg());
        1: instr = op_fp(F5_MUL, fmt, rand_reg(), rand_reg(), 3'b000, rand_reg());
        2: instr = op_fp(F5_DIV, fmt, rand_reg(), rand_reg(), 3'b000, rand_reg());
        3: instr = op_fp(F5_SQRT, fmt, 0, rand_reg(), 3'b000, rand_reg());
        4: instr = op_fp(F5_CMP, fmt, rand_reg(), rand_reg(), 3'b010, rand_reg());
        5: instr = op_fp(F5_CVT_INT, fmt, 0, rand_reg(), 3'b000, rand_reg());
        6: instr = op_fp(F5_CVT_FP, fmt, 0, rand_reg(), 3'b000, rand_reg());
        7: instr = op_fp(F5_MV_X, 2'b00, 0, rand_reg(), 3'b001, rand_reg());
        8: instr = fma(OPC_FMADD, rand_reg(), fmt, rand_reg(), rand_reg(), rand_reg());
        default: instr = fma(OPC_FNMSUB, rand_reg(), fmt, rand_reg(), rand_reg(), rand_reg());
      endcase
      issue_op(instr, r, $urandom);
    end
    drain_results();

    // Dependent op waits for the flagged result
    issue_op(op_fp(F5_ADD, 2'b00, 2, 1, 3'b000, 5), 1, $urandom);
    issue_op(op_fp(F5_MUL, 2'b01, 5, 5, 3'b000, 6), 2, $urandom);
    drain_results();
    issue_op(op_fp(F5_MV_X, 2'b00, 0, 5, 3'b000, 10), 3, $urandom);
    drain_results();

    // Non-FP instructions pass through, the first result held by the core
    instr = $urandom;
    instr[6:0] = 7'b0110011;
    issue_op(instr, 7, $urandom);
    core_result_ready <= 1'b0;
    do @(negedge clk); while (!core_result_valid);
    repeat (3) @(posedge clk);
    core_result_ready <= 1'b1;
    instr = $urandom;
    instr[6:0] = 7'b0010011;
    issue_op(instr, 12, $urandom);
    drain_results();

    // Illegal funct5, fmt and funct3
    issue_op(op_fp(5'b01111, 2'b00, 1, 2, 3'b000, 3), 8, $urandom);
    issue_op(op_fp(F5_ADD, 2'b10, 1, 2, 3'b000, 3), 9, $urandom);
    issue_op(fma(OPC_FMSUB, 4, 2'b11, 1, 2, 3), 10, $urandom);
    issue_op(op_fp(F5_MV_X, 2'b00, 0, 2, 3'b010, 3), 11, $urandom);
    drain_results();

    // Core back-pressure on the move register
    @(posedge clk);
    core_result_ready <= 1'b0;
    issue_op(op_fp(F5_MV_X, 2'b00, 0, 12, 3'b000, 1), 20, $urandom);
    do @(negedge clk); while (!core_result_valid);
    @(posedge clk);
    issue_valid <= 1'b1;
    issue_instr <= op_fp(F5_MV_X, 2'b00, 0, 13, 3'b000, 2);
    issue_id    <= 5'd21;
    repeat (8) begin
      @(negedge clk);
      check_flag("issue_ready_o", issue_ready, 1'b0);
    end
    @(posedge clk);
    core_result_ready <= 1'b1;
    do @(negedge clk); while (!issue_ready);
    @(posedge clk);
    issue_valid <= 1'b0;
    drain_results();

    if (stall_seen == 0) begin
      stop_on_error("The scoreboard never held back a dependent instruction");
    end else begin
      $display("all tests passed");
      $finish;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/fp_decoder.sv ====
//////////////////////////////
// FP instruction decoder
// Register use, move and legality of an offered instruction
//////////////////////////////

`default_nettype none

module fp_decoder import fp_seq_pkg::*; (
  input  instr_t       instr_i,
  output fp_reg_addr_t fd_o,
  output fp_reg_addr_t fs1_o,
  output fp_reg_addr_t fs2_o,
  output fp_reg_addr_t fs3_o,
  output logic         use_fd_o,
  output logic         use_fs1_o,
  output logic         use_fs2_o,
  output logic         use_fs3_o,
  output logic         use_rd_o,
  output logic         is_move_o,
  output logic         illegal_o
);

  opcode_t    opcode;
  funct5_t    funct5;
  logic [1:0] fmt;
  logic [2:0] funct3;
  logic       fmt_ok;

  assign opcode = instr_i[6:0];
  assign funct3 = instr_i[14:12];
  assign fmt    = instr_i[26:25];
  assign funct5 = instr_i[31:27];

  // Only single and double formats
  assign fmt_ok = (fmt == 2'b00) || (fmt == 2'b01);

  assign fd_o  = instr_i[FD_LSB  +: FP_REG_W];
  assign fs1_o = instr_i[FS1_LSB +: FP_REG_W];
  assign fs2_o = instr_i[FS2_LSB +: FP_REG_W];
  assign fs3_o = instr_i[FS3_LSB +: FP_REG_W];

  always_comb begin
    // Non-FP instructions use no FP registers
    use_fd_o  = 1'b0;
    use_fs1_o = 1'b0;
    use_fs2_o = 1'b0;
    use_fs3_o = 1'b0;
    use_rd_o  = 1'b0;
    is_move_o = 1'b0;
    illegal_o = 1'b0;

    case (opcode)
      OPC_FMADD, OPC_FMSUB, OPC_FNMSUB, OPC_FNMADD: begin
        if (fmt_ok) begin
          use_fs1_o = 1'b1;
          use_fs2_o = 1'b1;
          use_fs3_o = 1'b1;
          use_fd_o  = 1'b1;
        end else begin
          illegal_o = 1'b1;
        end
      end
      OPC_OP_FP: begin
        if (!fmt_ok) begin
          illegal_o = 1'b1;
        end else begin
          case (funct5)
            F5_ADD, F5_SUB, F5_MUL, F5_DIV, F5_SGNJ, F5_MINMAX: begin
              use_fs1_o = 1'b1;
              use_fs2_o = 1'b1;
              use_fd_o  = 1'b1;
            end
            F5_SQRT: begin
              use_fs1_o = 1'b1;
              use_fd_o  = 1'b1;
            end
            F5_CMP: begin
              use_fs1_o = 1'b1;
              use_fs2_o = 1'b1;
            end
            F5_CVT_INT: use_fs1_o = 1'b1;
            F5_CVT_FP:  use_fd_o  = 1'b1;
            F5_MV_X: begin
              // FMV.X.W runs here, FCLASS goes to the accelerator
              if (funct3 == 3'b000) begin
                use_fs1_o = 1'b1;
                use_rd_o  = 1'b1;
                is_move_o = 1'b1;
              end else if (funct3 == 3'b001) begin
                use_fs1_o = 1'b1;
              end else begin
                illegal_o = 1'b1;
              end
            end
            F5_MV_F: begin
              use_fd_o  = 1'b1;
              is_move_o = 1'b1;
            end
            default: illegal_o = 1'b1;
          endcase
        end
      end
      default: ;
    endcase
  end

endmodule

`default_nettype wire

// ==== verilog/fp_dispatch.sv ====
//////////////////////////////
// FP issue dispatch
// Stall, handshake, operand substitution and issue response
//////////////////////////////

`default_nettype none

module fp_dispatch import fp_seq_pkg::*; (
  input  logic         issue_valid_i,
  input  instr_t       issue_instr_i,
  input  core_id_t     issue_id_i,
  input  xlen_t        issue_rs1_i,
  input  xlen_t        issue_rs2_i,
  input  xlen_t        issue_rs3_i,
  input  logic         acc_ready_i,
  input  logic         acc_accept_i,
  input  logic         acc_writeback_i,
  input  logic         operands_ready_i,
  input  logic         move_full_i,
  input  fp_reg_addr_t fd_i,
  input  logic         use_fd_i,
  input  logic         use_fs1_i,
  input  logic         use_fs2_i,
  input  logic         use_fs3_i,
  input  logic         use_rd_i,
  input  logic         is_move_i,
  input  logic         illegal_i,
  input  fp_data_t     rdata0_i,
  input  fp_data_t     rdata1_i,
  input  fp_data_t     rdata2_i,
  output logic         issue_ready_o,
  output logic         issue_accept_o,
  output logic         issue_writeback_o,
  output logic         issue_exc_o,
  output logic         acc_valid_o,
  output instr_t       acc_instr_o,
  output acc_tag_t     acc_tag_o,
  output xlen_t        acc_rs1_o,
  output xlen_t        acc_rs2_o,
  output xlen_t        acc_rs3_o,
  output logic         sb_set_o,
  output logic         move_in_we_o,
  output logic         move_out_load_o
);

  logic is_local;
  logic stall;
  logic issue_fire;

  // Moves and illegal encodings never reach the accelerator
  assign is_local = is_move_i || illegal_i;
  assign stall    = !operands_ready_i || (is_move_i && use_rd_i && move_full_i);

  assign issue_ready_o = !stall && (is_local || acc_ready_i);
  assign acc_valid_o   = issue_valid_i && !stall && !is_local;
  assign issue_fire    = issue_valid_i && issue_ready_o;

  ////////////////////////////////
  // Forwarded request
  ////////////////////////////////

  assign acc_instr_o = issue_instr_i;
  assign acc_tag_o   = use_fd_i ? {1'b1, fd_i} : {1'b0, issue_id_i};
  assign acc_rs1_o   = use_fs1_i ? xlen_t'(rdata0_i) : issue_rs1_i;
  assign acc_rs2_o   = use_fs2_i ? xlen_t'(rdata1_i) : issue_rs2_i;
  assign acc_rs3_o   = use_fs3_i ? xlen_t'(rdata2_i) : issue_rs3_i;

  // Local response or the accelerator's own
  assign issue_accept_o    = is_local ? is_move_i : acc_accept_i;
  assign issue_writeback_o = is_local ? (is_move_i && use_rd_i) : acc_writeback_i;
  assign issue_exc_o       = is_local && illegal_i;

  // Strobes on the issue transfer
  assign sb_set_o        = issue_fire && !is_local && use_fd_i;
  assign move_in_we_o    = issue_fire && is_move_i && use_fd_i;
  assign move_out_load_o = issue_fire && is_move_i && use_rd_i;

endmodule

`default_nettype wire

// ==== verilog/fp_regfile.sv ====
//////////////////////////////
// FP register file
// 32 entries, three read ports, two write ports
//////////////////////////////

`default_nettype none

module fp_regfile import fp_seq_pkg::*; (
  input  logic         clk_i,
  input  fp_reg_addr_t raddr0_i,
  input  fp_reg_addr_t raddr1_i,
  input  fp_reg_addr_t raddr2_i,
  input  logic         we0_i,
  input  logic         we1_i,
  input  fp_reg_addr_t waddr0_i,
  input  fp_reg_addr_t waddr1_i,
  input  fp_data_t     wdata0_i,
  input  fp_data_t     wdata1_i,
  output fp_data_t     rdata0_o,
  output fp_data_t     rdata1_o,
  output fp_data_t     rdata2_o
);

  fp_data_t mem [NR_FP_REG];

  // Port 0 is written last so it wins on an address clash
  always_ff @(posedge clk_i) begin
    if (we1_i)
      mem[waddr1_i] <= wdata1_i;
    if (we0_i)
      mem[waddr0_i] <= wdata0_i;
  end

  assign rdata0_o = mem[raddr0_i];
  assign rdata1_o = mem[raddr1_i];
  assign rdata2_o = mem[raddr2_i];

endmodule

`default_nettype wire

// ==== verilog/fp_retire.sv ====
//////////////////////////////
// FP result retire
// Routes accelerator results, holds FMV.X.W results
//////////////////////////////

`default_nettype none

module fp_retire import fp_seq_pkg::*; (
  input  logic         clk_i,
  input  logic         rst_n_i,
  input  logic         move_out_load_i,
  input  fp_data_t     move_data_i,
  input  core_id_t     move_id_i,
  input  logic         acc_result_valid_i,
  input  acc_tag_t     acc_result_tag_i,
  input  fp_data_t     acc_result_data_i,
  output logic         acc_result_ready_o,
  output logic         core_result_valid_o,
  output core_id_t     core_result_id_o,
  output xlen_t        core_result_data_o,
  input  logic         core_result_ready_i,
  output logic         move_full_o,
  output logic         we0_o,
  output fp_reg_addr_t waddr0_o,
  output fp_data_t     wdata0_o,
  output logic         retire_o,
  output fp_reg_addr_t retire_addr_o
);

  logic     fpr_flag;
  logic     acc_to_core;
  logic     move_pop;
  logic     move_valid_q;
  fp_data_t move_data_q;
  core_id_t move_id_q;

  assign fpr_flag    = acc_result_tag_i[ID_W];
  assign acc_to_core = acc_result_valid_i && !fpr_flag;

  ////////////////////////////////
  // Move result holding register
  ////////////////////////////////

  // Non-FP accelerator results go first
  assign move_pop = move_valid_q && !acc_to_core && core_result_ready_i;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      move_valid_q <= 1'b0;
    end else if (move_out_load_i) begin
      move_valid_q <= 1'b1;
    end else if (move_pop) begin
      move_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (move_out_load_i) begin
      move_data_q <= move_data_i;
      move_id_q   <= move_id_i;
    end
  end

  // Load only happens when empty, so no pass-through path is needed
  assign move_full_o = move_valid_q;

  ////////////////////////////////
  // Result routing
  ////////////////////////////////

  // FPR writes are always taken
  assign acc_result_ready_o = fpr_flag || core_result_ready_i;

  assign core_result_valid_o = acc_to_core || move_valid_q;
  assign core_result_id_o    = acc_to_core ? acc_result_tag_i[ID_W-1:0] : move_id_q;
  assign core_result_data_o  = acc_to_core ? xlen_t'(acc_result_data_i)
                                           : xlen_t'(move_data_q);

  // FPR write port 0 and scoreboard clear
  assign we0_o    = acc_result_valid_i && fpr_flag;
  assign waddr0_o = acc_result_tag_i[FP_REG_W-1:0];
  assign wdata0_o = acc_result_data_i;

  assign retire_o      = we0_o;
  assign retire_addr_o = waddr0_o;

endmodule

`default_nettype wire

// ==== verilog/fp_scoreboard.sv ====
//////////////////////////////
// FP register scoreboard
// One pending bit per FPR, checked against the operands in use
//////////////////////////////

`default_nettype none

module fp_scoreboard import fp_seq_pkg::*; (
  input  logic         clk_i,
  input  logic         rst_n_i,
  input  fp_reg_addr_t fd_i,
  input  fp_reg_addr_t fs1_i,
  input  fp_reg_addr_t fs2_i,
  input  fp_reg_addr_t fs3_i,
  input  logic         use_fd_i,
  input  logic         use_fs1_i,
  input  logic         use_fs2_i,
  input  logic         use_fs3_i,
  input  logic         set_i,
  input  logic         retire_i,
  input  fp_reg_addr_t retire_addr_i,
  output logic         operands_ready_o
);

  logic [NR_FP_REG-1:0] pending_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      pending_q <= '0;
    end else begin
      // A new writer of fd cannot issue while fd is still pending
      if (retire_i)
        pending_q[retire_addr_i] <= 1'b0;
      if (set_i)
        pending_q[fd_i] <= 1'b1;
    end
  end

  assign operands_ready_o = !((use_fs1_i && pending_q[fs1_i]) ||
                              (use_fs2_i && pending_q[fs2_i]) ||
                              (use_fs3_i && pending_q[fs3_i]) ||
                              (use_fd_i  && pending_q[fd_i]));

endmodule

`default_nettype wire

// ==== verilog/fp_seq_pkg.sv ====
//////////////////////////////
// FP issue sequencer package
// Widths, RISC-V FP opcodes, funct5 codes and shared types
//////////////////////////////

`default_nettype none

package fp_seq_pkg;

  // Data and index widths
  localparam int unsigned XLEN      = 32;
  localparam int unsigned FLEN      = 32;
  localparam int unsigned NR_FP_REG = 32;
  localparam int unsigned FP_REG_W  = 5;
  localparam int unsigned ID_W      = 5;

  // Register field positions in the instruction word
  localparam int unsigned FD_LSB  = 7;
  localparam int unsigned FS1_LSB = 15;
  localparam int unsigned FS2_LSB = 20;
  localparam int unsigned FS3_LSB = 27;

  typedef logic [31:0]         instr_t;
  typedef logic [FLEN-1:0]     fp_data_t;
  typedef logic [XLEN-1:0]     xlen_t;
  typedef logic [FP_REG_W-1:0] fp_reg_addr_t;
  typedef logic [ID_W-1:0]     core_id_t;
  // Top bit flags an FPR write, low bits hold fd or the core id
  typedef logic [ID_W:0]       acc_tag_t;
  typedef logic [6:0]          opcode_t;
  typedef logic [4:0]          funct5_t;

  localparam opcode_t OPC_OP_FP  = 7'b1010011;
  localparam opcode_t OPC_FMADD  = 7'b1000011;
  localparam opcode_t OPC_FMSUB  = 7'b1000111;
  localparam opcode_t OPC_FNMSUB = 7'b1001011;
  localparam opcode_t OPC_FNMADD = 7'b1001111;

  // funct5 codes, instruction bits 31..27
  localparam funct5_t F5_ADD     = 5'b00000;
  localparam funct5_t F5_SUB     = 5'b00001;
  localparam funct5_t F5_MUL     = 5'b00010;
  localparam funct5_t F5_DIV     = 5'b00011;
  localparam funct5_t F5_SGNJ    = 5'b00100;
  localparam funct5_t F5_MINMAX  = 5'b00101;
  localparam funct5_t F5_SQRT    = 5'b01011;
  localparam funct5_t F5_CMP     = 5'b10100;
  localparam funct5_t F5_CVT_INT = 5'b11000;
  localparam funct5_t F5_CVT_FP  = 5'b11010;
  localparam funct5_t F5_MV_X    = 5'b11100;
  localparam funct5_t F5_MV_F    = 5'b11110;

endpackage

`default_nettype wire

// ==== verilog/fp_sequencer.sv ====
//////////////////////////////
// FP issue sequencer
// Owns the FPR, forwards FP work to the accelerator
//////////////////////////////

`default_nettype none

module fp_sequencer import fp_seq_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_n_i,
  // Issue from the core
  input  logic     issue_valid_i,
  input  instr_t   issue_instr_i,
  input  core_id_t issue_id_i,
  input  xlen_t    issue_rs1_i,
  input  xlen_t    issue_rs2_i,
  input  xlen_t    issue_rs3_i,
  output logic     issue_ready_o,
  output logic     issue_accept_o,
  output logic     issue_writeback_o,
  output logic     issue_exc_o,
  // Issue to the accelerator
  output logic     acc_valid_o,
  output instr_t   acc_instr_o,
  output acc_tag_t acc_tag_o,
  output xlen_t    acc_rs1_o,
  output xlen_t    acc_rs2_o,
  output xlen_t    acc_rs3_o,
  input  logic     acc_ready_i,
  input  logic     acc_accept_i,
  input  logic     acc_writeback_i,
  // Accelerator results
  input  logic     acc_result_valid_i,
  input  acc_tag_t acc_result_tag_i,
  input  fp_data_t acc_result_data_i,
  output logic     acc_result_ready_o,
  // Core results
  output logic     core_result_valid_o,
  output core_id_t core_result_id_o,
  output xlen_t    core_result_data_o,
  input  logic     core_result_ready_i
);

  fp_reg_addr_t fd, fs1, fs2, fs3;
  logic         use_fd, use_fs1, use_fs2, use_fs3, use_rd;
  logic         is_move, illegal;
  logic         operands_ready, move_full;
  logic         sb_set, move_in_we, move_out_load;
  logic         we0, retire;
  fp_reg_addr_t waddr0, retire_addr;
  fp_data_t     wdata0, rdata0, rdata1, rdata2;

  fp_decoder u_decoder (
    .instr_i   (issue_instr_i), .fd_o(fd), .fs1_o(fs1), .fs2_o(fs2), .fs3_o(fs3),
    .use_fd_o  (use_fd),  .use_fs1_o(use_fs1), .use_fs2_o(use_fs2),
    .use_fs3_o (use_fs3), .use_rd_o(use_rd),   .is_move_o(is_move),
    .illegal_o (illegal)
  );

  fp_scoreboard u_scoreboard (
    .clk_i     (clk_i), .rst_n_i(rst_n_i),
    .fd_i      (fd),      .fs1_i(fs1),         .fs2_i(fs2),         .fs3_i(fs3),
    .use_fd_i  (use_fd),  .use_fs1_i(use_fs1), .use_fs2_i(use_fs2), .use_fs3_i(use_fs3),
    .set_i     (sb_set),  .retire_i(retire),   .retire_addr_i(retire_addr),
    .operands_ready_o(operands_ready)
  );

  // Port 1 takes FMV.W.X data straight from the integer operand
  fp_regfile u_regfile (
    .clk_i    (clk_i),
    .raddr0_i (fs1),    .raddr1_i(fs2),   .raddr2_i(fs3),
    .we0_i    (we0),    .waddr0_i(waddr0), .wdata0_i(wdata0),
    .we1_i    (move_in_we), .waddr1_i(fd), .wdata1_i(fp_data_t'(issue_rs1_i)),
    .rdata0_o (rdata0), .rdata1_o(rdata1), .rdata2_o(rdata2)
  );

  fp_dispatch u_dispatch (
    .issue_valid_i    (issue_valid_i),   .issue_instr_i(issue_instr_i),
    .issue_id_i       (issue_id_i),      .issue_rs1_i(issue_rs1_i),
    .issue_rs2_i      (issue_rs2_i),     .issue_rs3_i(issue_rs3_i),
    .acc_ready_i      (acc_ready_i),     .acc_accept_i(acc_accept_i),
    .acc_writeback_i  (acc_writeback_i), .operands_ready_i(operands_ready),
    .move_full_i      (move_full),       .fd_i(fd),
    .use_fd_i         (use_fd),  .use_fs1_i(use_fs1), .use_fs2_i(use_fs2),
    .use_fs3_i        (use_fs3), .use_rd_i(use_rd),   .is_move_i(is_move),
    .illegal_i        (illegal),
    .rdata0_i         (rdata0),  .rdata1_i(rdata1),   .rdata2_i(rdata2),
    .issue_ready_o    (issue_ready_o),     .issue_accept_o(issue_accept_o),
    .issue_writeback_o(issue_writeback_o), .issue_exc_o(issue_exc_o),
    .acc_valid_o      (acc_valid_o), .acc_instr_o(acc_instr_o), .acc_tag_o(acc_tag_o),
    .acc_rs1_o        (acc_rs1_o),   .acc_rs2_o(acc_rs2_o),     .acc_rs3_o(acc_rs3_o),
    .sb_set_o         (sb_set), .move_in_we_o(move_in_we), .move_out_load_o(move_out_load)
  );

  fp_retire u_retire (
    .clk_i              (clk_i), .rst_n_i(rst_n_i),
    .move_out_load_i    (move_out_load), .move_data_i(rdata0), .move_id_i(issue_id_i),
    .acc_result_valid_i (acc_result_valid_i), .acc_result_tag_i(acc_result_tag_i),
    .acc_result_data_i  (acc_result_data_i),  .acc_result_ready_o(acc_result_ready_o),
    .core_result_valid_o(core_result_valid_o), .core_result_id_o(core_result_id_o),
    .core_result_data_o (core_result_data_o),  .core_result_ready_i(core_result_ready_i),
    .move_full_o        (move_full),
    .we0_o              (we0), .waddr0_o(waddr0), .wdata0_o(wdata0),
    .retire_o           (retire), .retire_addr_o(retire_addr)
  );

endmodule

`default_nettype wire
